//--- build.f
+incdir+.
img_pkg.sv
frame_pkg.sv
img_delay.sv
img_hfilter.sv
frame_fsm.sv
frame_counter.sv
img_filter_top.sv
tb_img_filter_top.sv

//--- frame_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "img_macros.svh"

module frame_counter
    import img_pkg::*;
    import frame_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            cke,
    input  wire img_sync_t m_sync,
    input  wire            line_start,
    input  wire            frame_end,
    output frame_stat_t    frame_stat
);

    localparam logic [`IMG_CNT_W-1:0] CNT_MAX = '1;

    logic [`IMG_CNT_W-1:0] pix_cnt;
    logic [`IMG_CNT_W-1:0] pix_next;
    logic [`IMG_CNT_W-1:0] line_cnt;
    logic [`IMG_CNT_W-1:0] line_next;
    logic [`IMG_CNT_W-1:0] height;
    logic                  beat;

    assign beat = cke & m_sync.valid;

    // Pixels in the current line, including this beat
    always_comb begin
        pix_next = line_start ? '0 : pix_cnt;
        if (beat && m_sync.de && pix_next != CNT_MAX) begin
            pix_next = pix_next + 1'b1;
        end
    end

    // Lines already finished in this frame
    always_comb begin
        line_next = line_cnt;
        if (line_start) begin
            if (m_sync.line_first) begin
                line_next = '0;
            end else if (line_cnt != CNT_MAX) begin
                line_next = line_cnt + 1'b1;
            end
        end
    end

    // The closing line counts too
    assign height = (line_next == CNT_MAX) ? CNT_MAX : line_next + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt    <= '0;
            line_cnt   <= '0;
            frame_stat <= '0;
        end else if (beat) begin
            pix_cnt  <= pix_next;
            line_cnt <= line_next;
            if (frame_end) begin
                frame_stat.width  <= pix_next;
                frame_stat.height <= height;
            end
        end
    end

    a_frame_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        frame_end |-> (pix_next != '0));

endmodule

`default_nettype wire

//--- frame_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module frame_fsm
    import img_pkg::*;
    import frame_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            cke,
    input  wire img_sync_t m_sync,
    output logic           line_start,
    output logic           frame_end,
    output logic           frame_done,
    output logic           sync_error
);

    frame_state_e state;
    frame_state_e state_next;
    logic         beat;
    logic         in_line;
    logic         err_now;
    logic         line_close;

    // Output beats hold while cke is low so only enabled ones count
    assign beat    = cke & m_sync.valid;
    assign in_line = (state == IN_LINE);

    // A pixel_first opens a line only when none is open
    assign line_start = beat & m_sync.pixel_first & !in_line;

    // First flag inside a line, or last flag with no line open
    assign err_now = beat & ((m_sync.pixel_first & in_line) |
                             (m_sync.pixel_last & !in_line & !m_sync.pixel_first));

    // Width-1 lines open and close on the same beat
    assign line_close = beat & m_sync.pixel_last & (in_line | line_start);

    // Broken closing beat does not report a frame
    assign frame_end = line_close & m_sync.line_last & !err_now;

    always_comb begin
        state_next = state;
        if (line_close) begin
            state_next = m_sync.line_last ? IDLE : BETWEEN_LINES;
        end else if (line_start) begin
            state_next = IN_LINE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            frame_done <= 1'b0;
            sync_error <= 1'b0;
        end else begin
            state      <= state_next;
            frame_done <= frame_end;
            sync_error <= err_now;
        end
    end

endmodule

`default_nettype wire

//--- frame_pkg.sv
`default_nettype none

`include "img_macros.svh"

package frame_pkg;

    // Line structure as seen by the frame monitor
    typedef enum logic [1:0] {
        IDLE          = 2'd0,
        IN_LINE       = 2'd1,
        BETWEEN_LINES = 2'd2
    } frame_state_e;

    // Size of the last completed frame
    typedef struct packed {
        logic [`IMG_CNT_W-1:0] width;
        logic [`IMG_CNT_W-1:0] height;
    } frame_stat_t;

endpackage

`default_nettype wire

//--- img_delay.sv
`timescale 1ns/100ps
`default_nettype none

module img_delay
    import img_pkg::*;
#(
    parameter int LATENCY = 1
)
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            cke,
    input  wire img_sync_t s_sync,
    output img_sync_t      m_sync
);

    img_sync_t chain [LATENCY];
    img_sync_t dly;

    // Shift chain cleared so that no beat is valid after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LATENCY; i++) begin
                chain[i] <= '0;
            end
        end else if (cke) begin
            chain[0] <= s_sync;
            for (int i = 1; i < LATENCY; i++) begin
                chain[i] <= chain[i-1];
            end
        end
    end

    assign dly = chain[LATENCY-1];

    // Flags only count on a valid beat
    always_comb begin
        m_sync.line_first  = dly.valid & dly.line_first;
        m_sync.line_last   = dly.valid & dly.line_last;
        m_sync.pixel_first = dly.valid & dly.pixel_first;
        m_sync.pixel_last  = dly.valid & dly.pixel_last;
        m_sync.de          = dly.valid & dly.de;
        m_sync.valid       = dly.valid;
    end

    // A stalled edge must leave the output untouched
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !cke |=> $stable(m_sync));

endmodule

`default_nettype wire

//--- img_filter_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "img_macros.svh"

module img_filter_top
    import img_pkg::*;
    import frame_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              cke,
    input  wire img_sync_t   s_sync,
    input  wire img_pix_t    s_data,
    output wire img_sync_t   m_sync,
    output wire img_pix_t    m_data,
    output wire              frame_done,
    output wire frame_stat_t frame_stat,
    output wire              sync_error
);

    wire line_start;
    wire frame_end;

    // Pixel path
    img_hfilter img_hfilter_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cke           (cke),
        .s_data        (s_data),
        .s_pixel_first (s_sync.pixel_first),
        .s_pixel_last  (s_sync.pixel_last),
        .m_data        (m_data)
    );

    // Sync path, matched to the filter depth
    img_delay #(
        .LATENCY (`IMG_FILTER_LATENCY)
    ) img_delay_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .cke    (cke),
        .s_sync (s_sync),
        .m_sync (m_sync)
    );

    // Frame monitor on the output stream
    frame_fsm frame_fsm_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cke        (cke),
        .m_sync     (m_sync),
        .line_start (line_start),
        .frame_end  (frame_end),
        .frame_done (frame_done),
        .sync_error (sync_error)
    );

    frame_counter frame_counter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cke        (cke),
        .m_sync     (m_sync),
        .line_start (line_start),
        .frame_end  (frame_end),
        .frame_stat (frame_stat)
    );

endmodule

`default_nettype wire

//--- img_hfilter.sv
`timescale 1ns/100ps
`default_nettype none

module img_hfilter
    import img_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           cke,
    input  wire img_pix_t s_data,
    input  wire           s_pixel_first,
    input  wire           s_pixel_last,
    output img_pix_t      m_data
);

    // Stage 1
    img_pix_t centre;
    img_pix_t left;
    logic     last_col;

    // Stage 2 operands
    img_pix_t right;
    img_sum_t sum;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            centre   <= '0;
            left     <= '0;
            last_col <= 1'b0;
        end else if (cke) begin
            // First column is its own left neighbour
            left     <= s_pixel_first ? s_data : centre;
            centre   <= s_data;
            last_col <= s_pixel_last;
        end
    end

    // The beat now at the input is the right neighbour,
    // except on the last column where the centre is reused
    assign right = last_col ? centre : s_data;

    // left + 2*centre + right + 2, cannot exceed 4*max+2
    assign sum = img_sum_t'(left)
               + {1'b0, centre, 1'b0}
               + img_sum_t'(right)
               + img_sum_t'(2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_data <= '0;
        end else if (cke) begin
            // Divide by four
            m_data <= sum[$bits(img_sum_t)-1:2];
        end
    end

endmodule

`default_nettype wire

//--- img_macros.svh
`ifndef IMG_MACROS_SVH
`define IMG_MACROS_SVH

// Width of one pixel sample
`define IMG_DATA_W 8

// Width and height counters of the frame monitor
`define IMG_CNT_W 12

// Pipeline depth of the horizontal filter
// The sync delay line runs at the same depth
`define IMG_FILTER_LATENCY 2

`endif

//--- img_pkg.sv
`default_nettype none

`include "img_macros.svh"

package img_pkg;

    // One pixel sample
    typedef logic [`IMG_DATA_W-1:0] img_pix_t;

    // 1-2-1 sum, two extra bits for a total weight of four
    typedef logic [`IMG_DATA_W+1:0] img_sum_t;

    // Raster sync flags, valid in the lowest bit
    typedef struct packed {
        logic line_first;
        logic line_last;
        logic pixel_first;
        logic pixel_last;
        logic de;
        logic valid;
    } img_sync_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module tb_img_filter_top -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -x "No errors" > /dev/null &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }

//--- tb_img_filter_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "img_macros.svh"

module tb_img_filter_top
    import img_pkg::*;
    import frame_pkg::*;
();

    localparam int NUM_ROWS = 6;

    // One test row of frame size, stall level in eighths, injected column and expected errors
    typedef struct packed {
        logic [`IMG_CNT_W-1:0] width;
        logic [`IMG_CNT_W-1:0] height;
        logic [2:0]            stall;
        logic [`IMG_CNT_W-1:0] inj_col;
        logic [3:0]            exp_err;
    } test_row_t;

    // Expected output beat
    typedef struct packed {
        img_sync_t sync;
        img_pix_t  data;
    } out_beat_t;

    logic        clk;
    logic        rst_n;
    logic        cke;
    img_sync_t   s_sync;
    img_pix_t    s_data;
    img_sync_t   m_sync;
    img_pix_t    m_data;
    logic        frame_done;
    frame_stat_t frame_stat;
    logic        sync_error;

    test_row_t   rows [NUM_ROWS];
    test_row_t   cur_row;
    out_beat_t   exp_q [$];
    out_beat_t   mon_beat;
    logic [31:0] rng;
    int          errors;
    int          done_cnt;
    int          err_cnt;
    int          cycles;
    int          limit;

    img_filter_top img_filter_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cke        (cke),
        .s_sync     (s_sync),
        .s_data     (s_data),
        .m_sync     (m_sync),
        .m_data     (m_data),
        .frame_done (frame_done),
        .frame_stat (frame_stat),
        .sync_error (sync_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // Hold one beat until an enabled edge takes it
    task automatic drive_beat(input img_sync_t sync, input img_pix_t data,
                              input logic [2:0] stall);
        logic taken;
        s_sync = sync;
        s_data = data;
        taken  = 1'b0;
        while (!taken) begin
            rng   = lcg_next(rng);
            cke   = (rng[30:28] >= stall);
            taken = cke;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic run_frame(input test_row_t row);
        img_pix_t  pix [64];
        img_sync_t syncs [64];
        img_sync_t gap;
        out_beat_t ob;
        int        w;
        int        h;
        int        lft;
        int        rgt;
        w = int'(row.width);
        h = int'(row.height);
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                rng    = lcg_next(rng);
                pix[x] = rng[23:16];
            end
            for (int x = 0; x < w; x++) begin
                syncs[x]             = '0;
                syncs[x].line_first  = (y == 0);
                syncs[x].line_last   = (y == h - 1);
                // Injected flag only on the first line
                syncs[x].pixel_first = (x == 0) ||
                    (y == 0 && row.inj_col != '0 && x == int'(row.inj_col));
                syncs[x].pixel_last  = (x == w - 1);
                syncs[x].de          = 1'b1;
                syncs[x].valid       = 1'b1;
                // Edge pixel replaces the missing neighbour
                lft     = syncs[x].pixel_first ? int'(pix[x]) : int'(pix[x-1]);
                rgt     = (x == w - 1) ? int'(pix[x]) : int'(pix[x+1]);
                ob.sync = syncs[x];
                ob.data = img_pix_t'((lft + 2 * int'(pix[x]) + rgt + 2) / 4);
                exp_q.push_back(ob);
            end
            for (int x = 0; x < w; x++) begin
                drive_beat(syncs[x], pix[x], row.stall);
            end
            // Gap beat with stale flags and valid low
            rng       = lcg_next(rng);
            gap       = img_sync_t'(rng[29:24]);
            gap.valid = 1'b0;
            drive_beat(gap, rng[23:16], row.stall);
        end
        s_sync = '0;
        s_data = '0;
        cke    = 1'b1;
        while (exp_q.size() != 0 || done_cnt == 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Output side sampled mid cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (cke && m_sync.valid) begin
                if (exp_q.size() == 0) begin
                    $display("Valid output beat arrived with no expected beat left at %0t",
                             $time);
                    errors++;
                end else begin
                    mon_beat = exp_q.pop_front();
                    check_value("m_data", 32'(m_data), 32'(mon_beat.data));
                    check_value("m_sync", 32'(m_sync), 32'(mon_beat.sync));
                end
            end else if (!m_sync.valid) begin
                check_value("m_sync", 32'(m_sync), 32'd0);
            end
            if (frame_done) begin
                done_cnt++;
                check_value("frame_stat", 32'(frame_stat),
                            32'({cur_row.width, cur_row.height}));
                check_value("sync_error", 32'(sync_error), 32'd0);
            end
            if (sync_error) begin
                err_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout, the run did not finish within %0d cycles", limit);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int sum;
        int row_errs;
        int failed;
        rst_n    = 1'b0;
        cke      = 1'b1;
        s_sync   = '0;
        s_data   = '0;
        rng      = 32'd36438;
        errors   = 0;
        done_cnt = 0;
        err_cnt  = 0;
        cycles   = 0;
        failed   = 0;
        rows[0]  = '{12'd8,  12'd4, 3'd0, 12'd0, 4'd0};
        rows[1]  = '{12'd1,  12'd3, 3'd0, 12'd0, 4'd0};
        rows[2]  = '{12'd16, 12'd5, 3'd2, 12'd0, 4'd0};
        rows[3]  = '{12'd12, 12'd3, 3'd2, 12'd5, 4'd1};
        rows[4]  = '{12'd2,  12'd2, 3'd1, 12'd0, 4'd0};
        rows[5]  = '{12'd33, 12'd6, 3'd2, 12'd0, 4'd0};
        cur_row  = rows[0];
        sum = 0;
        foreach (rows[i]) begin
            sum += (int'(rows[i].width) + 1) * int'(rows[i].height);
        end
        limit = 2 * sum + 100;

        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // Idle outputs straight after reset
        @(negedge clk);
        check_value("m_sync", 32'(m_sync), 32'd0);
        check_value("m_data", 32'(m_data), 32'd0);
        check_value("frame_done", 32'(frame_done), 32'd0);
        check_value("sync_error", 32'(sync_error), 32'd0);
        check_value("frame_stat", 32'(frame_stat), 32'd0);
        @(posedge clk);
        #2;

        for (int t = 0; t < NUM_ROWS; t++) begin
            row_errs = errors;
            cur_row  = rows[t];
            done_cnt = 0;
            err_cnt  = 0;
            run_frame(rows[t]);
            check_value("frame_done count", 32'(done_cnt), 32'd1);
            check_value("sync_error count", 32'(err_cnt), 32'(rows[t].exp_err));
            if (errors == row_errs) begin
                $display("Test %0d frame %0dx%0d stall %0d: ok", t, rows[t].width,
                         rows[t].height, rows[t].stall);
            end else begin
                $display("Test %0d frame %0dx%0d stall %0d: %0d mismatches", t,
                         rows[t].width, rows[t].height, rows[t].stall, errors - row_errs);
                failed++;
            end
        end

        $display("Tests %0d, failed %0d, errors %0d", NUM_ROWS, failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
